// File: common/platform_pkg.sv
package platform_pkg;

    typedef logic [9:0] x_t;
    typedef logic [8:0] y_t;

    typedef enum logic [1:0] {
        GAME_PLAYING = 2'd0,
        GAME_WIN     = 2'd1,
        GAME_LOSE    = 2'd2
    } game_state_e;

    typedef enum logic [1:0] {
        JUMP_IDLE = 2'd0,
        JUMP_RISE = 2'd1,
        JUMP_FALL = 2'd2
    } jump_state_e;

    // keyboard set 2 scan codes
    typedef enum logic [7:0] {
        SC_A     = 8'h1C,
        SC_W     = 8'h1D,
        SC_D     = 8'h23,
        SC_BREAK = 8'hF0
    } scan_code_e;

    // object boxes in pixels
    localparam int PLAYER_W  = 47;
    localparam int PLAYER_H  = 41;
    localparam int BLOCK_W   = 25;
    localparam int BLOCK_H   = 42;
    localparam int FLAKE_W   = 24;
    localparam int FLAKE_H   = 26;
    localparam int MONSTER_W = 34;
    localparam int MONSTER_H = 33;

    localparam int GROUND_NUM  = 50;
    localparam int FLOOR_NUM   = 22;
    localparam int FLAKE_NUM   = 15;
    localparam int MONSTER_NUM = 2;

    // map rows, first block index of each row
    localparam int LEDGE_A_FIRST = 22;
    localparam int LEDGE_B_FIRST = 29;
    localparam int UPPER_FIRST   = 36;
    localparam int FLOOR_Y       = 400;
    localparam int LEDGE_Y       = 310;
    localparam int UPPER_Y       = 230;

    localparam int START_X = 0;
    localparam int START_Y = 359;
    localparam int X_MAX   = 503;

    // cycles per one-pixel step
    localparam int MOVE_PERIOD = 4;
    localparam int JUMP_PERIOD = 4;
    localparam int FALL_PERIOD = 4;
    localparam int JUMP_HEIGHT = 60;
    localparam int STEP_W      = 8;
    localparam int RISE_W      = $clog2(JUMP_HEIGHT + 1);

    localparam int HEALTH_INIT = 3;
    localparam int HEALTH_W    = 4;
    localparam int SCORE_W     = 4;

    // start, 8 data, parity, stop
    localparam int PS2_FRAME_W = 11;

    function automatic x_t block_x(input int idx);
        if (idx < LEDGE_A_FIRST) begin
            return x_t'(BLOCK_W * idx);
        end else if (idx < LEDGE_B_FIRST) begin
            return x_t'(100 + BLOCK_W * (idx - LEDGE_A_FIRST));
        end else if (idx < UPPER_FIRST) begin
            return x_t'(300 + BLOCK_W * (idx - LEDGE_B_FIRST));
        end
        return x_t'(200 + BLOCK_W * (idx - UPPER_FIRST));
    endfunction

    function automatic y_t block_y(input int idx);
        if (idx < LEDGE_A_FIRST) begin
            return y_t'(FLOOR_Y);
        end else if (idx < UPPER_FIRST) begin
            return y_t'(LEDGE_Y);
        end
        return y_t'(UPPER_Y);
    endfunction

    // snowflakes hang in one column
    function automatic x_t flake_x(input int idx);
        return x_t'(144 + 0 * idx);
    endfunction

    function automatic y_t flake_y(input int idx);
        return y_t'(26 * idx);
    endfunction

    function automatic x_t monster_x(input int idx);
        return (idx == 0) ? x_t'(250) : x_t'(300);
    endfunction

    function automatic y_t monster_y(input int idx);
        return (idx == 0) ? y_t'(197) : y_t'(367);
    endfunction

    // half-open spans [a, a+alen) and [b, b+blen) share a pixel
    function automatic logic span_overlap(input int a, input int alen,
                                          input int b, input int blen);
        return (a < b + blen) && (a + alen > b);
    endfunction

endpackage

// File: ps2/ps2_receiver.sv
`timescale 1ns/10ps
module ps2_receiver (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       ps2_clk_i,
    input  logic       ps2_data_i,
    output logic [7:0] scan_byte_o,
    output logic       byte_valid_o
);
    import platform_pkg::*;

    logic [1:0]             clk_sync;
    logic [1:0]             data_sync;
    logic                   clk_prev;
    logic                   fall_edge;
    logic [PS2_FRAME_W-1:0] frame;
    logic [PS2_FRAME_W-1:0] frame_next;
    logic [3:0]             bit_cnt;
    logic                   last_bit;
    logic                   frame_ok;

    // both lines idle high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk_i};
            data_sync <= {data_sync[0], ps2_data_i};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall_edge = clk_prev && !clk_sync[1];

    // lsb first, so shift in from the top
    assign frame_next = {data_sync[1], frame[PS2_FRAME_W-1:1]};
    assign last_bit   = (bit_cnt == 4'(PS2_FRAME_W - 1));
    // start low, odd parity over data and parity bit, stop high
    assign frame_ok   = !frame_next[0] && (^frame_next[9:1]) && frame_next[10];

    always_ff @(posedge clk) begin
        if (fall_edge) begin
            frame <= frame_next;
        end
        if (fall_edge && last_bit && frame_ok) begin
            scan_byte_o <= frame_next[8:1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bit_cnt      <= '0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            if (fall_edge) begin
                if (last_bit) begin
                    bit_cnt      <= '0;
                    byte_valid_o <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/key_decoder.sv
`timescale 1ns/10ps
module key_decoder (
    input  logic       clk,
    input  logic       reset_i,
    input  logic [7:0] scan_byte_i,
    input  logic       byte_valid_i,
    output logic       key_w_o,
    output logic       key_a_o,
    output logic       key_d_o
);
    import platform_pkg::*;

    logic break_pending;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            break_pending <= 1'b0;
            key_w_o       <= 1'b0;
            key_a_o       <= 1'b0;
            key_d_o       <= 1'b0;
        end else if (byte_valid_i) begin
            if (scan_byte_i == SC_BREAK) begin
                break_pending <= 1'b1;
            end else begin
                // any code consumes the prefix, even an unknown one
                break_pending <= 1'b0;
                case (scan_byte_i)
                    SC_W:    key_w_o <= !break_pending;
                    SC_A:    key_a_o <= !break_pending;
                    SC_D:    key_d_o <= !break_pending;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: verilog/terrain_collision.sv
`timescale 1ns/10ps
module terrain_collision (
    input  logic             clk,
    input  logic             reset_i,
    input  platform_pkg::x_t x_i,
    input  platform_pkg::y_t y_i,
    output logic             on_ground_o,
    output logic             hit_ceiling_o,
    output logic             hit_right_o,
    output logic             hit_left_o,
    output logic             floor_done_o
);
    import platform_pkg::*;

    logic [GROUND_NUM-1:0] ground_hit;
    logic [GROUND_NUM-1:0] ceil_hit;
    logic [GROUND_NUM-1:0] right_hit;
    logic [GROUND_NUM-1:0] left_hit;
    logic [FLOOR_NUM-1:0]  stood_mask;

    always_comb begin
        int  px;
        int  py;
        int  bx;
        int  by;
        logic h_ov;
        logic v_ov;
        px = int'(x_i);
        py = int'(y_i);
        for (int i = 0; i < GROUND_NUM; i++) begin
            bx   = int'(block_x(i));
            by   = int'(block_y(i));
            h_ov = span_overlap(px, PLAYER_W, bx, BLOCK_W);
            v_ov = span_overlap(py, PLAYER_H, by, BLOCK_H);
            // adjacent on one axis, overlapping on the other
            ground_hit[i] = h_ov && (py + PLAYER_H == by);
            ceil_hit[i]   = h_ov && (py == by + BLOCK_H);
            right_hit[i]  = v_ov && (px + PLAYER_W == bx);
            left_hit[i]   = v_ov && (px == bx + BLOCK_W);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            on_ground_o   <= 1'b0;
            hit_ceiling_o <= 1'b0;
            hit_right_o   <= 1'b0;
            hit_left_o    <= 1'b0;
            stood_mask    <= '0;
        end else begin
            on_ground_o   <= |ground_hit;
            hit_ceiling_o <= |ceil_hit;
            hit_right_o   <= |right_hit;
            hit_left_o    <= |left_hit;
            // floor row only, sticky until reset
            stood_mask    <= stood_mask | ground_hit[FLOOR_NUM-1:0];
        end
    end

    assign floor_done_o = &stood_mask;

endmodule

// File: verilog/player_motion.sv
`timescale 1ns/10ps
module player_motion (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      key_w_i,
    input  logic                      key_a_i,
    input  logic                      key_d_i,
    input  logic                      on_ground_i,
    input  logic                      hit_ceiling_i,
    input  logic                      hit_right_i,
    input  logic                      hit_left_i,
    input  platform_pkg::game_state_e game_state_i,
    output platform_pkg::x_t          x_o,
    output platform_pkg::y_t          y_o
);
    import platform_pkg::*;

    jump_state_e       jump_state;
    logic [STEP_W-1:0] h_timer;
    logic [STEP_W-1:0] v_timer;
    logic [RISE_W-1:0] rise_cnt;
    logic              playing;
    logic              step_right;
    logic              step_left;

    assign playing    = (game_state_i == GAME_PLAYING);
    // D wins over A
    assign step_right = key_d_i && !hit_right_i && (x_o < x_t'(X_MAX));
    assign step_left  = key_a_i && !key_d_i && !hit_left_i && (x_o != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            x_o     <= x_t'(START_X);
            h_timer <= '0;
        end else if (playing) begin
            if (step_right || step_left) begin
                if (h_timer == STEP_W'(MOVE_PERIOD - 1)) begin
                    h_timer <= '0;
                    x_o     <= step_right ? x_o + 1'b1 : x_o - 1'b1;
                end else begin
                    h_timer <= h_timer + 1'b1;
                end
            end else begin
                h_timer <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            y_o        <= y_t'(START_Y);
            jump_state <= JUMP_IDLE;
            v_timer    <= '0;
            rise_cnt   <= '0;
        end else if (playing) begin
            if (jump_state == JUMP_RISE) begin
                if (hit_ceiling_i || rise_cnt == RISE_W'(JUMP_HEIGHT)) begin
                    jump_state <= JUMP_FALL;
                    v_timer    <= '0;
                end else if (v_timer == STEP_W'(JUMP_PERIOD - 1)) begin
                    v_timer  <= '0;
                    y_o      <= y_o - 1'b1;
                    rise_cnt <= rise_cnt + 1'b1;
                end else begin
                    v_timer <= v_timer + 1'b1;
                end
            end else if (on_ground_i) begin
                v_timer <= '0;
                if (jump_state == JUMP_IDLE && key_w_i) begin
                    jump_state <= JUMP_RISE;
                    rise_cnt   <= '0;
                end else if (!key_w_i) begin
                    // one jump per press, W must be let go after landing
                    jump_state <= JUMP_IDLE;
                end
            end else if (v_timer == STEP_W'(FALL_PERIOD - 1)) begin
                // falling from idle too, e.g. walking off a ledge
                v_timer <= '0;
                y_o     <= y_o + 1'b1;
            end else begin
                v_timer <= v_timer + 1'b1;
            end
        end
    end

endmodule

// File: verilog/pickup_tracker.sv
`timescale 1ns/10ps
module pickup_tracker (
    input  logic                              clk,
    input  logic                              reset_i,
    input  platform_pkg::x_t                  x_i,
    input  platform_pkg::y_t                  y_i,
    input  platform_pkg::game_state_e         game_state_i,
    output logic [platform_pkg::SCORE_W-1:0]  score_o,
    output logic [platform_pkg::HEALTH_W-1:0] health_o
);
    import platform_pkg::*;

    logic [FLAKE_NUM-1:0]   flake_hit;
    logic [FLAKE_NUM-1:0]   collected;
    logic [FLAKE_NUM-1:0]   new_hit;
    logic [MONSTER_NUM-1:0] monster_hit;
    logic                   monster_touch;
    logic                   monster_prev;

    always_comb begin
        int px;
        int py;
        px = int'(x_i);
        py = int'(y_i);
        for (int i = 0; i < FLAKE_NUM; i++) begin
            flake_hit[i] = span_overlap(px, PLAYER_W, int'(flake_x(i)), FLAKE_W) &&
                           span_overlap(py, PLAYER_H, int'(flake_y(i)), FLAKE_H);
        end
        for (int j = 0; j < MONSTER_NUM; j++) begin
            monster_hit[j] = span_overlap(px, PLAYER_W, int'(monster_x(j)), MONSTER_W) &&
                             span_overlap(py, PLAYER_H, int'(monster_y(j)), MONSTER_H);
        end
    end

    // only first touch of each flake scores
    assign new_hit       = flake_hit & ~collected;
    assign monster_touch = |monster_hit;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            collected    <= '0;
            score_o      <= '0;
            health_o     <= HEALTH_W'(HEALTH_INIT);
            monster_prev <= 1'b0;
        end else if (game_state_i == GAME_PLAYING) begin
            collected    <= collected | flake_hit;
            score_o      <= score_o + SCORE_W'($countones(new_hit));
            monster_prev <= monster_touch;
            // rising edge of contact, saturate at zero
            if (monster_touch && !monster_prev && health_o != '0) begin
                health_o <= health_o - 1'b1;
            end
        end
    end

endmodule

// File: verilog/game_referee.sv
`timescale 1ns/10ps
module game_referee (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [platform_pkg::HEALTH_W-1:0] health_i,
    input  logic                              floor_done_i,
    output platform_pkg::game_state_e         game_state_o
);
    import platform_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            game_state_o <= GAME_PLAYING;
        end else begin
            case (game_state_o)
                GAME_PLAYING: begin
                    // losing wins a tie
                    if (health_i == '0) begin
                        game_state_o <= GAME_LOSE;
                    end else if (floor_done_i) begin
                        game_state_o <= GAME_WIN;
                    end
                end
                // win and lose hold until reset
                GAME_WIN:  game_state_o <= GAME_WIN;
                GAME_LOSE: game_state_o <= GAME_LOSE;
                default:   game_state_o <= GAME_PLAYING;
            endcase
        end
    end

endmodule

// File: verilog/snow_platformer_top.sv
`timescale 1ns/10ps
module snow_platformer_top (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              ps2_clk_i,
    input  logic                              ps2_data_i,
    output platform_pkg::x_t                  x_o,
    output platform_pkg::y_t                  y_o,
    output logic [platform_pkg::SCORE_W-1:0]  score_o,
    output logic [platform_pkg::HEALTH_W-1:0] health_o,
    output platform_pkg::game_state_e         game_state_o
);
    import platform_pkg::*;

    logic [7:0] scan_byte;
    logic       byte_valid;
    logic       key_w;
    logic       key_a;
    logic       key_d;
    logic       on_ground;
    logic       hit_ceiling;
    logic       hit_right;
    logic       hit_left;
    logic       floor_done;

    ps2_receiver i_ps2_receiver (
        .clk          (clk),
        .reset_i      (reset_i),
        .ps2_clk_i    (ps2_clk_i),
        .ps2_data_i   (ps2_data_i),
        .scan_byte_o  (scan_byte),
        .byte_valid_o (byte_valid)
    );

    key_decoder i_key_decoder (
        .clk          (clk),
        .reset_i      (reset_i),
        .scan_byte_i  (scan_byte),
        .byte_valid_i (byte_valid),
        .key_w_o      (key_w),
        .key_a_o      (key_a),
        .key_d_o      (key_d)
    );

    player_motion i_player_motion (
        .clk           (clk),
        .reset_i       (reset_i),
        .key_w_i       (key_w),
        .key_a_i       (key_a),
        .key_d_i       (key_d),
        .on_ground_i   (on_ground),
        .hit_ceiling_i (hit_ceiling),
        .hit_right_i   (hit_right),
        .hit_left_i    (hit_left),
        .game_state_i  (game_state_o),
        .x_o           (x_o),
        .y_o           (y_o)
    );

    terrain_collision i_terrain_collision (
        .clk           (clk),
        .reset_i       (reset_i),
        .x_i           (x_o),
        .y_i           (y_o),
        .on_ground_o   (on_ground),
        .hit_ceiling_o (hit_ceiling),
        .hit_right_o   (hit_right),
        .hit_left_o    (hit_left),
        .floor_done_o  (floor_done)
    );

    pickup_tracker i_pickup_tracker (
        .clk          (clk),
        .reset_i      (reset_i),
        .x_i          (x_o),
        .y_i          (y_o),
        .game_state_i (game_state_o),
        .score_o      (score_o),
        .health_o     (health_o)
    );

    game_referee i_game_referee (
        .clk          (clk),
        .reset_i      (reset_i),
        .health_i     (health_o),
        .floor_done_i (floor_done),
        .game_state_o (game_state_o)
    );

endmodule

// File: tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// 8 system cycles per PS/2 half period
localparam int PS2_HALF_CYCLES = 8;
localparam int FRAME_CYCLES    = 11 * 2 * PS2_HALF_CYCLES;

task automatic wait_cycles(input int count);
    repeat (count) @(posedge clk);
endtask

// quiet time between frames
task automatic idle_gap();
    wait_cycles(4 + int'($urandom % 8));
endtask

// start bit, data lsb first, odd parity, stop bit
task automatic send_ps2_frame(input logic [7:0] code, input bit bad_parity);
    logic [10:0] bits;
    logic        parity;
    parity = ~^code;
    if (bad_parity) begin
        parity = ~parity;
    end
    bits = {1'b1, parity, code, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 11; i++) begin
        // data moves while the PS/2 clock is high
        ps2_data <= bits[i];
        wait_cycles(PS2_HALF_CYCLES);
        ps2_clk <= 1'b0;
        wait_cycles(PS2_HALF_CYCLES);
        ps2_clk <= 1'b1;
    end
    ps2_data <= 1'b1;
endtask

task automatic send_code(input logic [7:0] code);
    idle_gap();
    send_ps2_frame(code, 1'b0);
endtask

// make code, then the break prefix ahead of time
// so that stopping later costs only one frame
task automatic start_walk(input logic [7:0] code);
    send_code(code);
    send_code(SC_BREAK);
endtask

task automatic stop_walk(input logic [7:0] code);
    send_code(code);
endtask

`endif

// File: tb/tb_snow_platformer.sv
`timescale 1ns/10ps
module tb_snow_platformer;
    import platform_pkg::*;

    logic                clk;
    logic                reset;
    logic                ps2_clk;
    logic                ps2_data;
    x_t                  x_pos;
    y_t                  y_pos;
    logic [SCORE_W-1:0]  score;
    logic [HEALTH_W-1:0] health;
    game_state_e         game_state;

    string test_name;
    int    error_count;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    int    x_prev;
    int    y_prev;
    int    x_gap;
    int    y_gap;
    int    score_prev;
    int    health_prev;

    `include "tb_tasks.svh"

    localparam int RAND_SEED    = 32'h65e5c9ad;
    localparam int RESET_CYCLES = 10;
    localparam int FLOOR_LEN    = FLOOR_NUM * BLOCK_W;
    localparam int WALK_LIMIT   = FLOOR_LEN * MOVE_PERIOD;
    localparam int NUM_TESTS    = 7;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * WALK_LIMIT + 40 * FRAME_CYCLES;
    localparam int Y_PEAK       = START_Y - JUMP_HEIGHT;
    localparam int Y_MIN_GAP    = (JUMP_PERIOD < FALL_PERIOD) ? JUMP_PERIOD : FALL_PERIOD;
    // first x at which the player box touches each target
    localparam int FLAKE_REACH_X   = 144 - PLAYER_W + 1;
    localparam int FLAKE_CLEAR_X   = 144 + FLAKE_W;
    localparam int MONSTER_REACH_X = 300 - PLAYER_W + 1;
    localparam int MONSTER_CLEAR_X = MONSTER_REACH_X - 14;
    localparam int WIN_X           = (FLOOR_NUM - 1) * BLOCK_W - PLAYER_W + 1;
    localparam int WALK_SHORT_X    = 20;

    snow_platformer_top i_dut (
        .clk          (clk),
        .reset_i      (reset),
        .ps2_clk_i    (ps2_clk),
        .ps2_data_i   (ps2_data),
        .x_o          (x_pos),
        .y_o          (y_pos),
        .score_o      (score),
        .health_o     (health),
        .game_state_o (game_state)
    );

    always #4 clk = ~clk;

    function automatic void note_failure(input string msg);
        $display("Failure in test %s: %s", test_name, msg);
        error_count++;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected)
        else begin
            $display("Error: test %s, %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name,
                     error_count - errors_at_start);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        wait_cycles(RESET_CYCLES);
        reset <= 1'b0;
        @(posedge clk);
    endtask

    function automatic bit x_short_of(input int target, input bit upward);
        return upward ? (int'(x_pos) < target) : (int'(x_pos) > target);
    endfunction

    task automatic wait_x_reach(input int target, input bit upward);
        int waited;
        waited = 0;
        while (x_short_of(target, upward) && waited < WALK_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (x_short_of(target, upward)) begin
            note_failure($sformatf("x stopped at %0d and never reached %0d", x_pos, target));
        end
    endtask

    task automatic wait_y_equal(input int target);
        int waited;
        waited = 0;
        while (int'(y_pos) != target && waited < WALK_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        check_value("y", target, y_pos);
    endtask

    task automatic wait_health(input int expected, input int limit);
        int waited;
        waited = 0;
        while (int'(health) != expected && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        check_value("health", expected, health);
    endtask

    task automatic wait_game_state(input game_state_e expected, input int limit);
        int waited;
        waited = 0;
        while (game_state != expected && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        check_value("game state", expected, game_state);
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        check_value("x", START_X, x_pos);
        check_value("y", START_Y, y_pos);
        check_value("score", 0, score);
        check_value("health", HEALTH_INIT, health);
        check_value("game state", GAME_PLAYING, game_state);
        // standing on the floor, nothing pulls y down
        wait_cycles(8 * FALL_PERIOD);
        check_value("y while idle", START_Y, y_pos);
        end_test();
    endtask

    task automatic test_jump();
        begin_test("jump");
        send_code(SC_W);
        wait_y_equal(Y_PEAK);
        wait_y_equal(START_Y);
        // W still held, no second jump
        wait_cycles(16 * FALL_PERIOD);
        check_value("y after landing", START_Y, y_pos);
        check_value("x during jump", START_X, x_pos);
        send_code(SC_BREAK);
        send_code(SC_W);
        wait_cycles(8 * JUMP_PERIOD);
        check_value("y after release", START_Y, y_pos);
        end_test();
    endtask

    task automatic test_parity_walk();
        int x_walk;
        int x_stop;
        begin_test("parity_and_walk");
        idle_gap();
        send_ps2_frame(SC_D, 1'b1);
        wait_cycles(8 * MOVE_PERIOD);
        check_value("x after bad parity frame", START_X, x_pos);
        start_walk(SC_D);
        wait_x_reach(WALK_SHORT_X, 1'b1);
        x_walk = x_pos;
        stop_walk(SC_D);
        wait_cycles(2 * MOVE_PERIOD);
        x_stop = x_pos;
        // the break prefix alone leaves D held
        assert (x_stop >= x_walk + FRAME_CYCLES / (2 * MOVE_PERIOD))
        else note_failure("player stopped before the release code arrived");
        wait_cycles(8 * MOVE_PERIOD);
        check_value("x after release", x_stop, x_pos);
        end_test();
    endtask

    task automatic test_snowflakes();
        begin_test("snowflakes");
        check_value("score", 0, score);
        start_walk(SC_D);
        wait_x_reach(FLAKE_REACH_X, 1'b1);
        wait_cycles(2);
        // flakes 13 and 14 are touched on the same step
        check_value("score at first flake x", 2, score);
        wait_x_reach(FLAKE_CLEAR_X, 1'b1);
        stop_walk(SC_D);
        check_value("score past flakes", 2, score);
        start_walk(SC_A);
        wait_x_reach(110, 1'b0);
        stop_walk(SC_A);
        check_value("score after walking back", 2, score);
        end_test();
    endtask

    task automatic test_monster();
        begin_test("monster");
        start_walk(SC_D);
        wait_x_reach(MONSTER_REACH_X, 1'b1);
        wait_health(HEALTH_INIT - 1, 4);
        stop_walk(SC_D);
        check_value("health while in contact", HEALTH_INIT - 1, health);
        start_walk(SC_A);
        wait_x_reach(MONSTER_CLEAR_X, 1'b0);
        stop_walk(SC_A);
        check_value("health after leaving", HEALTH_INIT - 1, health);
        start_walk(SC_D);
        wait_x_reach(MONSTER_REACH_X, 1'b1);
        wait_health(HEALTH_INIT - 2, 4);
        stop_walk(SC_D);
        check_value("health after second contact", HEALTH_INIT - 2, health);
        end_test();
    endtask

    task automatic test_floor_win();
        begin_test("floor_win");
        send_code(SC_D);
        wait_game_state(GAME_WIN, WALK_LIMIT);
        check_value("x at win", WIN_X, x_pos);
        check_value("health at win", HEALTH_INIT - 2, health);
        wait_cycles(8 * MOVE_PERIOD);
        check_value("x after win", WIN_X, x_pos);
        end_test();
    endtask

    task automatic test_monster_lose();
        begin_test("monster_lose");
        apply_reset();
        check_value("health after reset", HEALTH_INIT, health);
        check_value("game state after reset", GAME_PLAYING, game_state);
        for (int hit = 1; hit <= HEALTH_INIT; hit++) begin
            start_walk(SC_D);
            wait_x_reach(MONSTER_REACH_X, 1'b1);
            wait_health(HEALTH_INIT - hit, 4);
            if (hit < HEALTH_INIT) begin
                stop_walk(SC_D);
                start_walk(SC_A);
                wait_x_reach(MONSTER_CLEAR_X, 1'b0);
                stop_walk(SC_A);
            end
        end
        wait_game_state(GAME_LOSE, 4);
        wait_cycles(8 * MOVE_PERIOD);
        check_value("x after lose", MONSTER_REACH_X, x_pos);
        end_test();
    endtask

    // step size, step spacing and range of the position
    always @(posedge clk) begin
        if (reset) begin
            x_prev      = START_X;
            y_prev      = START_Y;
            x_gap       = MOVE_PERIOD;
            y_gap       = Y_MIN_GAP;
            score_prev  = 0;
            health_prev = HEALTH_INIT;
        end else begin
            x_gap++;
            y_gap++;
            if (int'(x_pos) != x_prev) begin
                assert (x_gap >= MOVE_PERIOD &&
                        (int'(x_pos) - x_prev) * (int'(x_pos) - x_prev) == 1)
                else note_failure($sformatf("x jumped from %0d to %0d after %0d cycles",
                                            x_prev, x_pos, x_gap));
                x_gap = 0;
            end
            if (int'(y_pos) != y_prev) begin
                assert (y_gap >= Y_MIN_GAP &&
                        (int'(y_pos) - y_prev) * (int'(y_pos) - y_prev) == 1)
                else note_failure($sformatf("y jumped from %0d to %0d after %0d cycles",
                                            y_prev, y_pos, y_gap));
                y_gap = 0;
            end
            assert (int'(y_pos) >= Y_PEAK && int'(y_pos) <= START_Y)
            else note_failure($sformatf("y is %0d, outside the jump range", y_pos));
            assert (int'(score) >= score_prev)
            else note_failure("score went down");
            assert (int'(health) <= health_prev)
            else note_failure("health went up");
            x_prev      = x_pos;
            y_prev      = y_pos;
            score_prev  = score;
            health_prev = health;
        end
    end

    // win and lose are final and freeze the player
    assert property (@(posedge clk)
        (!reset && game_state != GAME_PLAYING) |=>
            (reset || (game_state == $past(game_state) && $stable(x_pos) && $stable(y_pos))))
    else note_failure("state or position changed after the game ended");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        test_name    = "startup";
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(RAND_SEED));
        apply_reset();
        test_reset_state();
        test_jump();
        test_parity_walk();
        test_snowflakes();
        test_monster();
        test_floor_win();
        test_monster_lose();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+tb
common/platform_pkg.sv
ps2/ps2_receiver.sv
verilog/key_decoder.sv
verilog/terrain_collision.sv
verilog/player_motion.sv
verilog/pickup_tracker.sv
verilog/game_referee.sv
verilog/snow_platformer_top.sv
tb/tb_snow_platformer.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_snow_platformer -Mdir obj_dir
	./obj_dir/Vtb_snow_platformer | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
